// ==== Makefile ====
# Verilator build and run for the memory subsystem testbench.

VERILATOR ?= verilator
TOP ?= tb_soc_mem
SEED ?= 4
LOG ?= sim.log
OBJ_DIR ?= obj_dir
FILELIST ?= src.f
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Grand_seed=$(SEED) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/axi_sram.sv ====
`timescale 1ns/1ps

module axi_sram #(
    parameter int mem_words = 256
) (
    input  logic clk,
    input  logic rst,
    input  logic awvalid, wvalid, wlast, bready, arvalid, rready,
    output logic awready, wready, bvalid, arready, rvalid, rlast,
    input  logic [soc_pkg::addr_w-1:0] awaddr, araddr,
    input  logic [soc_pkg::id_w-1:0] awid, arid,
    input  logic [soc_pkg::data_w-1:0] wdata,
    input  logic [soc_pkg::data_w/8-1:0] wstrb,
    output logic [1:0] bresp, rresp,
    output logic [soc_pkg::id_w-1:0] bid, rid,
    output logic [soc_pkg::data_w-1:0] rdata
);

    localparam int idx_w = $clog2(mem_words);
    localparam int strb_w = soc_pkg::data_w / 8;

    logic [soc_pkg::data_w-1:0] mem [mem_words];
    logic aw_seen, w_seen, aw_beat, w_beat, ar_beat, wr_go;
    logic [soc_pkg::addr_w-1:0] awaddr_q, wr_addr;
    logic [soc_pkg::id_w-1:0] awid_q;
    logic [soc_pkg::data_w-1:0] wdata_q, wr_data;
    logic [strb_w-1:0] wstrb_q, wr_strb;
    logic [idx_w-1:0] rd_idx, wr_idx;

    assign ar_beat = arvalid && arready;
    assign aw_beat = awvalid && awready;
    assign w_beat = wvalid && wready;
    assign arready = !rvalid;
    assign awready = !aw_seen && !bvalid;
    assign wready = !w_seen && !bvalid;
    assign wr_go = (aw_seen || aw_beat) && (w_seen || w_beat);
    // a beat landing this cycle bypasses its holding register.
    assign wr_addr = aw_seen ? awaddr_q : awaddr;
    assign wr_data = w_seen ? wdata_q : wdata;
    assign wr_strb = w_seen ? wstrb_q : wstrb;
    assign rd_idx = idx_w'(araddr[soc_pkg::addr_w-1:2] % mem_words);
    assign wr_idx = idx_w'(wr_addr[soc_pkg::addr_w-1:2] % mem_words);
    assign rresp = soc_pkg::resp_okay;
    assign bresp = soc_pkg::resp_okay;
    assign rlast = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            aw_seen <= 1'b0;
            w_seen <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (bvalid && bready) bvalid <= 1'b0;
            if (wr_go) begin
                aw_seen <= 1'b0;
                w_seen <= 1'b0;
                bvalid <= 1'b1;
            end else begin
                if (aw_beat) aw_seen <= 1'b1;
                if (w_beat) w_seen <= 1'b1;
            end
            if (ar_beat) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_beat) begin
            awaddr_q <= awaddr;
            awid_q <= awid;
        end
        if (w_beat) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (wr_go) begin
            bid <= aw_seen ? awid_q : awid;
            for (int i = 0; i < strb_w; i++) begin
                if (wr_strb[i]) mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
        if (ar_beat) begin
            rdata <= mem[rd_idx];
            rid <= arid;
        end
    end

    assert property (@(posedge clk) disable iff (rst) w_beat |-> wlast);

endmodule

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic ifu_arvalid, ifu_rready,
    output logic ifu_arready, ifu_rvalid, ifu_rlast,
    input  logic [soc_pkg::addr_w-1:0] ifu_araddr,
    input  logic [soc_pkg::id_w-1:0] ifu_arid,
    output logic [soc_pkg::data_w-1:0] ifu_rdata,
    output logic [1:0] ifu_rresp,
    output logic [soc_pkg::id_w-1:0] ifu_rid,
    input  logic lsu_arvalid, lsu_rready, lsu_awvalid, lsu_wvalid, lsu_wlast, lsu_bready,
    output logic lsu_arready, lsu_rvalid, lsu_rlast, lsu_awready, lsu_wready, lsu_bvalid,
    input  logic [soc_pkg::addr_w-1:0] lsu_araddr, lsu_awaddr,
    input  logic [soc_pkg::id_w-1:0] lsu_arid, lsu_awid,
    input  logic [soc_pkg::data_w-1:0] lsu_wdata,
    input  logic [soc_pkg::data_w/8-1:0] lsu_wstrb,
    output logic [soc_pkg::data_w-1:0] lsu_rdata,
    output logic [1:0] lsu_rresp, lsu_bresp,
    output logic [soc_pkg::id_w-1:0] lsu_rid, lsu_bid,
    output logic mem_arvalid, mem_rready, mem_awvalid, mem_wvalid, mem_wlast, mem_bready,
    input  logic mem_arready, mem_rvalid, mem_rlast, mem_awready, mem_wready, mem_bvalid,
    output logic [soc_pkg::addr_w-1:0] mem_araddr, mem_awaddr,
    output logic [soc_pkg::id_w-1:0] mem_arid, mem_awid,
    output logic [soc_pkg::data_w-1:0] mem_wdata,
    output logic [soc_pkg::data_w/8-1:0] mem_wstrb,
    input  logic [soc_pkg::data_w-1:0] mem_rdata,
    input  logic [1:0] mem_rresp, mem_bresp,
    input  logic [soc_pkg::id_w-1:0] mem_rid, mem_bid,
    output logic clint_arvalid, clint_rready,
    input  logic clint_arready, clint_rvalid, clint_rlast,
    output logic [soc_pkg::addr_w-1:0] clint_araddr,
    output logic [soc_pkg::id_w-1:0] clint_arid,
    input  logic [soc_pkg::data_w-1:0] clint_rdata,
    input  logic [1:0] clint_rresp,
    input  logic [soc_pkg::id_w-1:0] clint_rid
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_ifu_grant = 2'd1;
    localparam logic [1:0] st_lsu_grant = 2'd2;

    logic [1:0] state;
    logic is_clint, clint_hit, grant_end, mem_r_end;

    assign mem_r_end = mem_rvalid && mem_rready && mem_rlast;
    assign clint_hit = lsu_araddr == soc_pkg::clint_base ||
                       lsu_araddr == soc_pkg::clint_base + 32'd4;

    always_comb begin
        case (state)
            st_ifu_grant: grant_end = mem_r_end;
            st_lsu_grant: grant_end = is_clint ? clint_rvalid && clint_rready && clint_rlast
                                               : mem_r_end || (mem_bvalid && mem_bready);
            default: grant_end = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            is_clint <= 1'b0;
        end else if (state == st_idle) begin
            if (lsu_arvalid || lsu_awvalid || lsu_wvalid) begin // lsu first.
                state <= st_lsu_grant;
                is_clint <= lsu_arvalid && clint_hit;
            end else if (ifu_arvalid) begin
                state <= st_ifu_grant;
            end
        end else if (grant_end) begin
            state <= st_idle;
        end
    end

    // handshakes reach only the granted master and the selected slave.
    always_comb begin
        ifu_arready = 1'b0;
        ifu_rvalid = 1'b0;
        lsu_arready = 1'b0;
        lsu_rvalid = 1'b0;
        lsu_awready = 1'b0;
        lsu_wready = 1'b0;
        lsu_bvalid = 1'b0;
        mem_arvalid = 1'b0;
        mem_rready = 1'b0;
        mem_awvalid = 1'b0;
        mem_wvalid = 1'b0;
        mem_bready = 1'b0;
        clint_arvalid = 1'b0;
        clint_rready = 1'b0;
        case (state)
            st_ifu_grant: begin
                mem_arvalid = ifu_arvalid;
                mem_rready = ifu_rready;
                ifu_arready = mem_arready;
                ifu_rvalid = mem_rvalid;
            end
            st_lsu_grant: begin
                if (is_clint) begin
                    clint_arvalid = lsu_arvalid;
                    clint_rready = lsu_rready;
                    lsu_arready = clint_arready;
                    lsu_rvalid = clint_rvalid;
                end else begin
                    mem_arvalid = lsu_arvalid;
                    mem_rready = lsu_rready;
                    mem_awvalid = lsu_awvalid;
                    mem_wvalid = lsu_wvalid;
                    mem_bready = lsu_bready;
                    lsu_arready = mem_arready;
                    lsu_rvalid = mem_rvalid;
                    lsu_awready = mem_awready;
                    lsu_wready = mem_wready;
                    lsu_bvalid = mem_bvalid;
                end
            end
            default: ;
        endcase
    end

    assign mem_araddr = (state == st_ifu_grant) ? ifu_araddr : lsu_araddr;
    assign mem_arid = (state == st_ifu_grant) ? ifu_arid : lsu_arid;
    assign mem_awaddr = lsu_awaddr;
    assign mem_awid = lsu_awid;
    assign mem_wdata = lsu_wdata;
    assign mem_wstrb = lsu_wstrb;
    assign mem_wlast = lsu_wlast;
    assign clint_araddr = lsu_araddr;
    assign clint_arid = lsu_arid;
    assign ifu_rdata = mem_rdata;
    assign ifu_rresp = mem_rresp;
    assign ifu_rlast = mem_rlast;
    assign ifu_rid = mem_rid;
    assign lsu_rdata = is_clint ? clint_rdata : mem_rdata;
    assign lsu_rresp = is_clint ? clint_rresp : mem_rresp;
    assign lsu_rlast = is_clint ? clint_rlast : mem_rlast;
    assign lsu_rid = is_clint ? clint_rid : mem_rid;
    assign lsu_bresp = mem_bresp;
    assign lsu_bid = mem_bid;

    // a load reaches one slave, picked by its address.
    assert property (@(posedge clk) disable iff (rst)
        state == st_lsu_grant && lsu_arvalid |->
            clint_arvalid == clint_hit && mem_arvalid == !clint_hit);

    // grant is dropped only once the slave has nothing left to return.
    assert property (@(posedge clk) disable iff (rst)
        state != st_idle ##1 state == st_idle |-> !mem_rvalid && !mem_bvalid && !clint_rvalid);

endmodule

// ==== hdl/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer (
    input  logic clk,
    input  logic rst,
    input  logic clint_arvalid, clint_rready,
    output logic clint_arready, clint_rvalid, clint_rlast,
    input  logic [soc_pkg::addr_w-1:0] clint_araddr,
    input  logic [soc_pkg::id_w-1:0] clint_arid,
    output logic [soc_pkg::data_w-1:0] clint_rdata,
    output logic [1:0] clint_rresp,
    output logic [soc_pkg::id_w-1:0] clint_rid
);

    soc_pkg::clint_time_t mtime;
    logic ar_beat;

    assign ar_beat = clint_arvalid && clint_arready;
    assign clint_arready = !clint_rvalid;
    assign clint_rresp = soc_pkg::resp_okay;
    assign clint_rlast = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtime <= '0;
            clint_rvalid <= 1'b0;
        end else begin
            mtime.count <= mtime.count + 64'd1;
            if (ar_beat) begin
                clint_rvalid <= 1'b1;
            end else if (clint_rready) begin
                clint_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_beat) begin
            clint_rdata <= clint_araddr[2] ? mtime.half.hi : mtime.half.lo; // sampled at ar.
            clint_rid <= clint_arid;
        end
    end

    // arbiter decode must only send the two mtime words here.
    assert property (@(posedge clk) disable iff (rst)
        clint_arvalid |-> clint_araddr[soc_pkg::addr_w-1:3] ==
                          soc_pkg::clint_base[soc_pkg::addr_w-1:3] &&
                          clint_araddr[1:0] == 2'b00);

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
    input  logic clk,
    input  logic rst,
    input  logic fetch_req,
    input  logic [soc_pkg::addr_w-1:0] fetch_pc,
    output logic fetch_done,
    output logic [soc_pkg::data_w-1:0] fetch_inst,
    output logic fetch_busy,
    output logic ifu_arvalid,
    input  logic ifu_arready,
    output logic [soc_pkg::addr_w-1:0] ifu_araddr,
    output logic [soc_pkg::id_w-1:0] ifu_arid,
    input  logic ifu_rvalid, ifu_rlast,
    output logic ifu_rready,
    input  logic [soc_pkg::data_w-1:0] ifu_rdata,
    input  logic [1:0] ifu_rresp,
    input  logic [soc_pkg::id_w-1:0] ifu_rid
);

    logic r_beat;

    assign r_beat = ifu_rvalid && ifu_rready;
    assign ifu_arid = soc_pkg::fetch_id;
    assign ifu_rready = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch_busy <= 1'b0;
            fetch_done <= 1'b0;
            ifu_arvalid <= 1'b0;
        end else begin
            fetch_done <= r_beat;
            if (fetch_req && !fetch_busy) begin
                fetch_busy <= 1'b1;
                ifu_arvalid <= 1'b1;
            end else if (ifu_arvalid && ifu_arready) begin
                ifu_arvalid <= 1'b0;
            end else if (r_beat) begin
                fetch_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req && !fetch_busy) begin
            ifu_araddr <= {fetch_pc[soc_pkg::addr_w-1:2], 2'b00}; // word aligned.
        end
        if (r_beat) begin
            fetch_inst <= ifu_rdata;
        end
    end

    // arbiter only routes r to the granted master, and the id comes back from the slave.
    assert property (@(posedge clk) disable iff (rst)
        ifu_rvalid |-> fetch_busy && !ifu_arvalid && ifu_rlast &&
                       ifu_rid == soc_pkg::fetch_id && ifu_rresp == soc_pkg::resp_okay);

endmodule

// ==== hdl/lsu_unit.sv ====
`timescale 1ns/1ps

module lsu_unit (
    input  logic clk,
    input  logic rst,
    input  logic mem_req, mem_we,
    input  logic [soc_pkg::addr_w-1:0] mem_addr,
    input  logic [soc_pkg::data_w-1:0] mem_wdata,
    input  logic [soc_pkg::data_w/8-1:0] mem_wstrb,
    output logic mem_done, mem_busy,
    output logic [soc_pkg::data_w-1:0] mem_rdata,
    output logic lsu_arvalid, lsu_rready,
    input  logic lsu_arready, lsu_rvalid, lsu_rlast,
    output logic [soc_pkg::addr_w-1:0] lsu_araddr,
    output logic [soc_pkg::id_w-1:0] lsu_arid,
    input  logic [soc_pkg::data_w-1:0] lsu_rdata,
    input  logic [1:0] lsu_rresp,
    input  logic [soc_pkg::id_w-1:0] lsu_rid,
    output logic lsu_awvalid, lsu_wvalid, lsu_wlast, lsu_bready,
    input  logic lsu_awready, lsu_wready, lsu_bvalid,
    output logic [soc_pkg::addr_w-1:0] lsu_awaddr,
    output logic [soc_pkg::id_w-1:0] lsu_awid,
    output logic [soc_pkg::data_w-1:0] lsu_wdata,
    output logic [soc_pkg::data_w/8-1:0] lsu_wstrb,
    input  logic [1:0] lsu_bresp,
    input  logic [soc_pkg::id_w-1:0] lsu_bid
);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_load = 2'd1;
    localparam logic [1:0] st_store = 2'd2;

    logic [1:0] state;
    logic [soc_pkg::addr_w-1:0] addr_q;
    logic start, r_beat, b_beat;

    assign start = mem_req && state == st_idle;
    assign r_beat = lsu_rvalid && lsu_rready;
    assign b_beat = lsu_bvalid && lsu_bready;
    assign mem_busy = state != st_idle;
    assign lsu_araddr = addr_q;
    assign lsu_awaddr = addr_q;
    assign lsu_arid = soc_pkg::lsu_id;
    assign lsu_awid = soc_pkg::lsu_id;
    assign lsu_wlast = 1'b1; // single beat only.
    assign lsu_rready = 1'b1;
    assign lsu_bready = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            mem_done <= 1'b0;
            lsu_arvalid <= 1'b0;
            lsu_awvalid <= 1'b0;
            lsu_wvalid <= 1'b0;
        end else begin
            mem_done <= r_beat || b_beat;
            case (state)
                st_idle: begin
                    if (mem_req) begin
                        state <= mem_we ? st_store : st_load;
                        lsu_arvalid <= !mem_we;
                        lsu_awvalid <= mem_we;
                        lsu_wvalid <= mem_we;
                    end
                end
                st_load: begin
                    if (lsu_arready) lsu_arvalid <= 1'b0;
                    if (r_beat) state <= st_idle;
                end
                st_store: begin
                    // aw and w drop independently, so either may finish first.
                    if (lsu_awready) lsu_awvalid <= 1'b0;
                    if (lsu_wready) lsu_wvalid <= 1'b0;
                    if (b_beat) state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= {mem_addr[soc_pkg::addr_w-1:2], 2'b00};
            lsu_wdata <= mem_wdata;
            lsu_wstrb <= mem_wstrb;
        end
        if (r_beat) begin
            mem_rdata <= lsu_rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(lsu_rvalid && lsu_bvalid));

    // responses come back only for the access in flight, carrying our id.
    assert property (@(posedge clk) disable iff (rst)
        lsu_rvalid |-> state == st_load && lsu_rlast &&
                       lsu_rid == soc_pkg::lsu_id && lsu_rresp == soc_pkg::resp_okay);
    assert property (@(posedge clk) disable iff (rst)
        lsu_bvalid |-> state == st_store && !lsu_awvalid && !lsu_wvalid &&
                       lsu_bid == soc_pkg::lsu_id && lsu_bresp == soc_pkg::resp_okay);

endmodule

// ==== hdl/soc_mem_top.sv ====
`timescale 1ns/1ps

module soc_mem_top #(
    parameter int mem_words = 256
) (
    input  logic clk,
    input  logic rst,
    input  logic fetch_req,
    input  logic [soc_pkg::addr_w-1:0] fetch_pc,
    output logic fetch_done,
    output logic [soc_pkg::data_w-1:0] fetch_inst,
    output logic fetch_busy,
    input  logic mem_req,
    input  logic mem_we,
    input  logic [soc_pkg::addr_w-1:0] mem_addr,
    input  logic [soc_pkg::data_w-1:0] mem_wdata,
    input  logic [soc_pkg::data_w/8-1:0] mem_wstrb,
    output logic mem_done,
    output logic [soc_pkg::data_w-1:0] mem_rdata,
    output logic mem_busy
);

    logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready, ifu_rlast;
    logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready, lsu_rlast, lsu_awvalid;
    logic lsu_awready, lsu_wvalid, lsu_wready, lsu_wlast, lsu_bvalid, lsu_bready;
    logic sram_arvalid, sram_arready, sram_rvalid, sram_rready, sram_rlast, sram_awvalid;
    logic sram_awready, sram_wvalid, sram_wready, sram_wlast, sram_bvalid, sram_bready;
    logic clint_arvalid, clint_arready, clint_rvalid, clint_rready, clint_rlast;
    logic [soc_pkg::addr_w-1:0] ifu_araddr, lsu_araddr, lsu_awaddr;
    logic [soc_pkg::addr_w-1:0] sram_araddr, sram_awaddr, clint_araddr;
    logic [soc_pkg::data_w-1:0] ifu_rdata, lsu_rdata, lsu_wdata;
    logic [soc_pkg::data_w-1:0] sram_rdata, sram_wdata, clint_rdata;
    logic [soc_pkg::data_w/8-1:0] lsu_wstrb, sram_wstrb;
    logic [soc_pkg::id_w-1:0] ifu_arid, ifu_rid, lsu_arid, lsu_rid, lsu_awid, lsu_bid;
    logic [soc_pkg::id_w-1:0] sram_arid, sram_rid, sram_awid, sram_bid, clint_arid, clint_rid;
    logic [1:0] ifu_rresp, lsu_rresp, lsu_bresp, sram_rresp, sram_bresp, clint_rresp;

    fetch_unit fetch_unit_inst (.*);

    lsu_unit lsu_unit_inst (.*);

    // downstream bus renamed to sram_* to keep clear of the lsu request ports.
    bus_arbiter bus_arbiter_inst (
        .mem_arvalid(sram_arvalid), .mem_arready(sram_arready), .mem_araddr(sram_araddr),
        .mem_arid(sram_arid), .mem_rvalid(sram_rvalid), .mem_rready(sram_rready),
        .mem_rdata(sram_rdata), .mem_rresp(sram_rresp), .mem_rlast(sram_rlast),
        .mem_rid(sram_rid), .mem_awvalid(sram_awvalid), .mem_awready(sram_awready),
        .mem_awaddr(sram_awaddr), .mem_awid(sram_awid), .mem_wvalid(sram_wvalid),
        .mem_wready(sram_wready), .mem_wdata(sram_wdata), .mem_wstrb(sram_wstrb),
        .mem_wlast(sram_wlast), .mem_bvalid(sram_bvalid), .mem_bready(sram_bready),
        .mem_bresp(sram_bresp), .mem_bid(sram_bid),
        .*
    );

    clint_timer clint_timer_inst (.*);

    axi_sram #(
        .mem_words(mem_words)
    ) axi_sram_inst (
        .clk, .rst,
        .arvalid(sram_arvalid), .arready(sram_arready), .araddr(sram_araddr),
        .arid(sram_arid), .rvalid(sram_rvalid), .rready(sram_rready),
        .rdata(sram_rdata), .rresp(sram_rresp), .rlast(sram_rlast), .rid(sram_rid),
        .awvalid(sram_awvalid), .awready(sram_awready), .awaddr(sram_awaddr),
        .awid(sram_awid), .wvalid(sram_wvalid), .wready(sram_wready),
        .wdata(sram_wdata), .wstrb(sram_wstrb), .wlast(sram_wlast),
        .bvalid(sram_bvalid), .bready(sram_bready), .bresp(sram_bresp), .bid(sram_bid)
    );

endmodule

// ==== hdl/soc_pkg.sv ====
package soc_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w = 4;

    localparam logic [id_w-1:0] fetch_id = 4'h1;
    localparam logic [id_w-1:0] lsu_id = 4'h2;

    // mtime low word, high word at +4.
    localparam logic [addr_w-1:0] clint_base = 32'h0200_0000;

    localparam logic [1:0] resp_okay = 2'b00;

    typedef union packed {
        logic [63:0] count;
        struct packed {
            logic [31:0] hi;
            logic [31:0] lo;
        } half;
    } clint_time_t;

endpackage

// ==== src.f ====
hdl/soc_pkg.sv
hdl/fetch_unit.sv
hdl/lsu_unit.sv
hdl/bus_arbiter.sv
hdl/clint_timer.sv
hdl/axi_sram.sv
hdl/soc_mem_top.sv
test/tb_soc_mem.sv

// ==== test/tb_soc_mem.sv ====
`timescale 1ns/1ps

module tb_soc_mem #(
    parameter int rand_seed = 4
);

    localparam int mem_words = 256;
    localparam int timeout = 200;
    localparam int n_words = 8;

    logic clk, rst;
    logic fetch_req, fetch_done, fetch_busy;
    logic [soc_pkg::addr_w-1:0] fetch_pc;
    logic [soc_pkg::data_w-1:0] fetch_inst;
    logic mem_req, mem_we, mem_done, mem_busy;
    logic [soc_pkg::addr_w-1:0] mem_addr;
    logic [soc_pkg::data_w-1:0] mem_wdata, mem_rdata;
    logic [soc_pkg::data_w/8-1:0] mem_wstrb;

    logic [soc_pkg::data_w-1:0] model [mem_words]; // shadow of the sram.
    logic [soc_pkg::addr_w-1:0] addrs [n_words];
    logic [soc_pkg::data_w-1:0] exp_rdata, exp_inst, timer_floor, cycles, r;
    logic [1:0] chk_mode; // 0 none, 1 data, 2 timer.
    logic reset_window, contend, mem_seen, fetch_seen;
    integer seed;
    int errors, tests, failed_tests, test_start_errors;
    string test_name;

    soc_mem_top #(.mem_words(mem_words)) soc_mem_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // same count as mtime.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) cycles <= '0;
        else cycles <= cycles + 1'b1;
    end

    assert property (@(posedge clk) mem_done && chk_mode == 2'd1 |-> mem_rdata == exp_rdata)
        else begin
            $display("[FAIL] %s: mem_rdata expected %h, actual %h", test_name,
                     $sampled(exp_rdata), $sampled(mem_rdata));
            errors++;
        end

    assert property (@(posedge clk) mem_done && chk_mode == 2'd2 |->
                     mem_rdata > timer_floor && mem_rdata <= cycles)
        else begin
            $display("[FAIL] %s: mtime expected > %0d and <= %0d, actual %0d", test_name,
                     $sampled(timer_floor), $sampled(cycles), $sampled(mem_rdata));
            errors++;
        end

    assert property (@(posedge clk) fetch_done |-> fetch_inst == exp_inst)
        else begin
            $display("[FAIL] %s: fetch_inst expected %h, actual %h", test_name,
                     $sampled(exp_inst), $sampled(fetch_inst));
            errors++;
        end

    assert property (@(posedge clk) contend && fetch_done |-> mem_seen)
        else begin
            $display("%s: the fetch finished before the load did", test_name);
            errors++;
        end

    assert property (@(posedge clk) reset_window |->
                     {fetch_done, mem_done, fetch_busy, mem_busy} == 4'b0000)
        else begin
            $display("[FAIL] %s: done and busy expected 0000, actual %b", test_name,
                     $sampled({fetch_done, mem_done, fetch_busy, mem_busy}));
            errors++;
        end

    function automatic int word_index(input logic [soc_pkg::addr_w-1:0] addr);
        return int'({2'b00, addr[soc_pkg::addr_w-1:2]} % mem_words);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] w;
        w = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) w[8*i +: 8] = data[8*i +: 8];
        end
        return w;
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_start_errors) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: FAILED with %0d errors", test_name, errors - test_start_errors);
            failed_tests++;
        end
    endtask

    task automatic wait_mem_done();
        int n;
        for (n = 0; n < timeout; n++) begin
            @(posedge clk);
            if (mem_done) break;
        end
        if (n == timeout) begin
            $display("%s: no mem_done within %0d cycles", test_name, timeout);
            errors++;
        end
    endtask

    task automatic do_store(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        @(posedge clk);
        chk_mode = 2'd0;
        model[word_index(addr)] = merge_bytes(model[word_index(addr)], data, strb);
        mem_req <= 1'b1;
        mem_we <= 1'b1;
        mem_addr <= addr;
        mem_wdata <= data;
        mem_wstrb <= strb;
        @(posedge clk);
        mem_req <= 1'b0;
        wait_mem_done();
    endtask

    task automatic do_load(input logic [31:0] addr, input logic [1:0] mode,
                           input logic [31:0] expv);
        @(posedge clk);
        exp_rdata = expv;
        chk_mode = mode;
        mem_req <= 1'b1;
        mem_we <= 1'b0;
        mem_addr <= addr;
        @(posedge clk);
        mem_req <= 1'b0;
        wait_mem_done();
    endtask

    task automatic do_fetch(input logic [31:0] pc);
        int n;
        @(posedge clk);
        exp_inst = model[word_index(pc)];
        fetch_req <= 1'b1;
        fetch_pc <= pc;
        @(posedge clk);
        fetch_req <= 1'b0;
        for (n = 0; n < timeout; n++) begin
            @(posedge clk);
            if (fetch_done) break;
        end
        if (n == timeout) begin
            $display("%s: no fetch_done within %0d cycles", test_name, timeout);
            errors++;
        end
    endtask

    task automatic run_contention(input logic [31:0] load_addr, input logic [31:0] pc);
        int n;
        @(posedge clk);
        exp_rdata = model[word_index(load_addr)];
        exp_inst = model[word_index(pc)];
        chk_mode = 2'd1;
        mem_seen = 1'b0;
        fetch_seen = 1'b0;
        contend = 1'b1;
        fetch_req <= 1'b1;
        fetch_pc <= pc;
        mem_req <= 1'b1;
        mem_we <= 1'b0;
        mem_addr <= load_addr;
        @(posedge clk);
        fetch_req <= 1'b0;
        mem_req <= 1'b0;
        for (n = 0; n < timeout; n++) begin
            @(posedge clk);
            if (mem_done) mem_seen = 1'b1;
            if (fetch_done) fetch_seen = 1'b1;
            if (mem_seen && fetch_seen) break;
        end
        if (n == timeout) begin
            $display("%s: both done pulses did not arrive within %0d cycles", test_name, timeout);
            errors++;
        end
        contend = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        fetch_req = 1'b0;
        fetch_pc = '0;
        mem_req = 1'b0;
        mem_we = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        chk_mode = 2'd0;
        exp_rdata = '0;
        exp_inst = '0;
        timer_floor = '0;
        contend = 1'b0;
        mem_seen = 1'b0;
        fetch_seen = 1'b0;
        reset_window = 1'b1;
        seed = rand_seed;
        errors = 0;
        tests = 0;
        failed_tests = 0;

        start_test("reset_state");
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        repeat (3) @(posedge clk);
        reset_window = 1'b0;
        end_test();

        start_test("store_load");
        for (int i = 0; i < n_words; i++) begin
            r = $random(seed);
            addrs[i] = r & 32'h0000_03fc; // below 0x400.
            r = $random(seed);
            do_store(addrs[i], r, 4'hf);
        end
        for (int i = 0; i < n_words; i++) do_load(addrs[i], 2'd1, model[word_index(addrs[i])]);
        end_test();

        start_test("byte_strobe");
        do_store(32'h0000_0200, 32'h1122_3344, 4'hf);
        do_store(32'h0000_0200, 32'haabb_ccdd, 4'b0101);
        do_load(32'h0000_0200, 2'd1, model[word_index(32'h0000_0200)]);
        r = $random(seed);
        do_store(32'h0000_0200, r, 4'b1000);
        do_load(32'h0000_0200, 2'd1, model[word_index(32'h0000_0200)]);
        end_test();

        start_test("fetch_stored");
        for (int i = 0; i < n_words; i++) do_fetch(addrs[i] | 32'd2); // misaligned pc.
        end_test();

        start_test("contention");
        run_contention(addrs[1], addrs[2]);
        run_contention(addrs[3], addrs[4]);
        end_test();

        start_test("timer");
        do_load(soc_pkg::clint_base, 2'd2, '0);
        timer_floor = mem_rdata;
        repeat (10) @(posedge clk);
        do_load(soc_pkg::clint_base, 2'd2, '0);
        do_load(soc_pkg::clint_base + 32'd4, 2'd1, '0);
        for (int i = 0; i < n_words; i++) do_load(addrs[i], 2'd1, model[word_index(addrs[i])]);
        end_test();

        $display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
